// ==== board_pkg.sv ====
`default_nettype none

package board_pkg;

    // ------------------------------
    // Rates and widths
    // ------------------------------

    localparam int clk_mhz           = 48;              // System clock, MHz
    localparam int w_tm_key          = 8;
    localparam int w_tm_led          = 8;
    localparam int w_tm_digit        = 8;
    localparam int w_sample          = 24;              // INMP441 word
    localparam int mic_sck_half      = clk_mhz / 12;    // 6 MHz bit clock
    localparam int mic_bits_per_word = 32;              // Per word-select half
    localparam int tm_clk_half       = clk_mhz / 12;    // 6 MHz panel clock
    localparam int scan_period       = 16;              // Cycles per shown digit

    // ------------------------------
    // Opcodes and FSM states
    // ------------------------------

    typedef enum logic [7:0] {
        cmd_write_auto = 8'h40,    // Data write, address auto increment
        cmd_read_keys  = 8'h42,
        cmd_addr0      = 8'hc0,
        cmd_display_on = 8'h8f     // Full brightness
    } tm_cmd_t;

    typedef enum logic [2:0] {
        st_idle,
        st_cmd_write,
        st_addr_data,
        st_cmd_display,
        st_cmd_read,
        st_read_keys,
        st_gap
    } tm_state_t;

    typedef enum logic [1:0] {
        st_wait_ws,
        st_skip,
        st_shift,
        st_ignore
    } i2s_state_t;

    // Segment a is the MSB, the decimal point stays dark
    function automatic logic [7:0] hex_to_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0:    hex_to_segments = 8'b1111_1100;
            4'h1:    hex_to_segments = 8'b0110_0000;
            4'h2:    hex_to_segments = 8'b1101_1010;
            4'h3:    hex_to_segments = 8'b1111_0010;
            4'h4:    hex_to_segments = 8'b0110_0110;
            4'h5:    hex_to_segments = 8'b1011_0110;
            4'h6:    hex_to_segments = 8'b1011_1110;
            4'h7:    hex_to_segments = 8'b1110_0000;
            4'h8:    hex_to_segments = 8'b1111_1110;
            4'h9:    hex_to_segments = 8'b1111_0110;
            4'ha:    hex_to_segments = 8'b1110_1110;
            4'hb:    hex_to_segments = 8'b0011_1110;
            4'hc:    hex_to_segments = 8'b1001_1100;
            4'hd:    hex_to_segments = 8'b0111_1010;
            4'he:    hex_to_segments = 8'b1001_1110;
            default: hex_to_segments = 8'b1000_1110;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== board_specific_top.sv ====
`default_nettype none

module board_specific_top
(
    input  logic clk,
    input  logic rst_n,

    output logic mic_sck,
    output logic mic_ws,
    output logic mic_lr,
    input  logic mic_sd,

    output logic sio_clk,
    output logic sio_stb,
    output logic sio_data_out,
    output logic sio_data_oe,
    input  logic sio_data_in
);

    logic [board_pkg::w_sample - 1:0]   sample;
    logic                               sample_valid;
    logic [7:0]                         abcdefgh;
    logic [7:0]                         hgfedcba;
    logic [board_pkg::w_tm_digit - 1:0] digit;
    logic [board_pkg::w_tm_led - 1:0]   led;
    logic [board_pkg::w_tm_key - 1:0]   keys;
    logic                               user_rst_n;

    // ------------------------------
    // Glue
    // ------------------------------

    assign user_rst_n = rst_n && !keys[board_pkg::w_tm_key - 1];  // Last key resets the meter

    for (genvar i = 0; i < 8; i++)
    begin : g_reverse
        assign hgfedcba[i] = abcdefgh[7 - i];    // Panel wants segment a in bit 0
    end

    // ------------------------------
    // Instances
    // ------------------------------

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sd           ( mic_sd       ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .lr           ( mic_lr       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    mic_level_display i_level
    (
        .clk          ( clk          ),
        .rst_n        ( user_rst_n   ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .keys         ( keys         ),
        .abcdefgh     ( abcdefgh     ),
        .digit        ( digit        ),
        .led          ( led          )
    );

    tm1638_board_controller i_tm1638
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .hgfedcba     ( hgfedcba     ),
        .digit        ( digit        ),
        .ledr         ( led          ),
        .keys         ( keys         ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  )
    );

endmodule

`default_nettype wire

// ==== files.f ====
board_pkg.sv
inmp441_mic_i2s_receiver.sv
mic_level_display.sv
tm1638_board_controller.sv
board_specific_top.sv
tb_tm1638_model.sv
tb_board_top.sv

// ==== inmp441_mic_i2s_receiver.sv ====
`default_nettype none

module inmp441_mic_i2s_receiver
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sd,
    output logic                             sck,
    output logic                             ws,
    output logic                             lr,
    output logic [board_pkg::w_sample - 1:0] sample,
    output logic                             sample_valid
);

    logic [$clog2(board_pkg::mic_sck_half) - 1:0]          div_cnt;
    logic [$clog2(2 * board_pkg::mic_bits_per_word) - 1:0] bit_cnt;
    logic                                                  div_end;
    logic                                                  sck_rise;
    logic                                                  sck_fall;
    logic                                                  last_bit;

    board_pkg::i2s_state_t                                 state;
    logic [board_pkg::w_sample - 2:0]                      shift_reg;

    // ------------------------------
    // Bit clock and word select
    // ------------------------------

    assign div_end  = int'(div_cnt) == board_pkg::mic_sck_half - 1;
    assign sck_rise = div_end && !sck;
    assign sck_fall = div_end && sck;
    assign last_bit = int'(bit_cnt) == board_pkg::w_sample;   // Delay bit sits at count 0

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            if (div_end)
            begin
                div_cnt <= '0;
                sck     <= !sck;
            end
            else
                div_cnt <= div_cnt + 1'b1;

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;      // ws moves with the falling edge
        end
    end

    assign ws = bit_cnt[$bits(bit_cnt) - 1];    // Low for the left half
    assign lr = 1'b0;                           // Select left channel

    // ------------------------------
    // Left channel capture
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= board_pkg::st_wait_ws;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= 1'b0;
            case (state)
                board_pkg::st_wait_ws:
                    if (!ws)
                        state <= board_pkg::st_skip;
                board_pkg::st_skip:
                    if (sck_rise)
                        state <= board_pkg::st_shift;   // Past the delay bit
                board_pkg::st_shift:
                    if (sck_rise && last_bit)
                    begin
                        state        <= board_pkg::st_ignore;
                        sample_valid <= 1'b1;
                    end
                default:
                    if (ws)
                        state <= board_pkg::st_wait_ws; // Right half is dropped
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == board_pkg::st_shift && sck_rise)
        begin
            shift_reg <= {shift_reg[board_pkg::w_sample - 3:0], sd};   // MSB first
            if (last_bit)
                sample <= {shift_reg, sd};
        end
    end

endmodule

`default_nettype wire

// ==== mic_level_display.sv ====
`default_nettype none

module mic_level_display
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [board_pkg::w_sample - 1:0]   sample,
    input  logic                               sample_valid,
    input  logic [board_pkg::w_tm_key - 1:0]   keys,
    output logic [7:0]                         abcdefgh,
    output logic [board_pkg::w_tm_digit - 1:0] digit,
    output logic [board_pkg::w_tm_led - 1:0]   led
);

    logic [board_pkg::w_sample - 1:0]                     magnitude;
    logic [board_pkg::w_sample - 1:0]                     peak;
    logic [$clog2(board_pkg::scan_period) - 1:0]          scan_cnt;
    logic [$clog2(board_pkg::w_tm_digit) - 1:0]           digit_idx;
    logic [board_pkg::w_tm_key + board_pkg::w_sample - 1:0] shown;

    // ------------------------------
    // Peak detector
    // ------------------------------

    always_comb
    begin
        if (!sample[board_pkg::w_sample - 1])
            magnitude = sample;
        else if (sample[board_pkg::w_sample - 2:0] == '0)
            magnitude = {1'b0, {(board_pkg::w_sample - 1){1'b1}}};  // Saturate full scale
        else
            magnitude = -sample;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            peak <= '0;
        else if (keys[0])
            peak <= '0;                         // Key 0 restarts the hold
        else if (sample_valid && magnitude > peak)
            peak <= magnitude;
    end

    // ------------------------------
    // Digit scan and LED bar
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end
        else if (int'(scan_cnt) == board_pkg::scan_period - 1)
        begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 1'b1;      // Wraps after digit 7
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    always_comb
    begin
        digit            = '0;
        digit[digit_idx] = 1'b1;
        for (int i = 0; i < board_pkg::w_tm_led; i++)
        begin
            led[i] = |(peak >> (15 + i));       // Peak at or above 2**(15+i)
        end
    end

    // Peak nibbles on digits 0 to 5, key byte on 6 and 7
    assign shown    = {keys, peak};
    assign abcdefgh = board_pkg::hex_to_segments(shown[digit_idx * 4 +: 4]);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the panel and microphone testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f files.f \
        --top-module tb_board_top -o sim_board; then
    echo "Verilator compile failed"
    exit 1
fi

if ! ./obj_dir/sim_board > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Failure found in $LOG"
    exit 1
fi

if ! grep -q "TEST PASSED" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi

exit 0

// ==== tb_board_top.sv ====
`default_nettype none

module tb_board_top;

    typedef struct packed {
        logic [23:0] peak;
        logic [63:0] segs;              // Byte i is digit i, panel order
        logic [7:0]  leds;
    } expect_t;

    localparam int max_cycles = 60000;

    logic        clk;
    logic        rst_n;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;
    logic        mic_sd;
    logic        sio_clk;
    logic        sio_stb;
    logic        sio_data_out;
    logic        sio_data_oe;
    logic        sio_data_in;
    logic [7:0]  key_byte;

    logic [23:0] hist [32];
    int          hist_n;
    logic [23:0] next_word;
    int          next_tag;
    int          done_tag;
    int          issue_cnt;
    int          fall_cnt;
    logic [23:0] cur_word;
    int          cur_tag;
    logic        sck_prev;
    int          cycles;

    board_specific_top u_board_specific_top
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .mic_lr       ( mic_lr       ),
        .mic_sd       ( mic_sd       ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  )
    );

    tb_tm1638_model u_panel
    (
        .clk          ( clk          ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .key_byte     ( key_byte     ),
        .sio_data_in  ( sio_data_in  )
    );

    always #10 clk = !clk;

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [7:0] hex_abcdefgh(input logic [3:0] n);
        logic [7:0] table_seg [16];
        table_seg = '{8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
                      8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e};
        return table_seg[n];
    endfunction

    function automatic logic [7:0] panel_order(input logic [7:0] s);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = s[7 - i];            // Segment a moves to bit 0
        return r;
    endfunction

    function automatic expect_t ref_display(input logic [23:0] h [32], input int n,
                                            input logic [7:0] k);
        expect_t     e;
        logic [23:0] m;
        logic [31:0] shown;
        e.peak = '0;
        for (int i = 0; i < n; i++)
        begin
            if (!h[i][23])
                m = h[i];
            else if (h[i] == 24'h800000)
                m = 24'h7fffff;         // Full scale negative saturates
            else
                m = -h[i];
            if (m > e.peak)
                e.peak = m;
        end
        shown = {k, e.peak};
        for (int d = 0; d < 8; d++)
            e.segs[d * 8 +: 8] = panel_order(hex_abcdefgh(shown[d * 4 +: 4]));
        for (int i = 0; i < 8; i++)
            e.leds[i] = e.peak >= (24'd1 << (15 + i));
        return e;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic report_failure(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_segments(input int idx, input logic [7:0] expected);
        if (u_panel.digits[idx] !== expected)
            report_failure($sformatf("digit %0d shows %h, expected %h", idx,
                                     u_panel.digits[idx], expected));
    endtask

    task automatic check_leds(input logic [7:0] expected);
        if (u_panel.leds !== expected)
            report_failure($sformatf("LEDs %b, expected %b", u_panel.leds, expected));
    endtask

    task automatic check_keys(input logic [7:0] expected);
        logic [7:0] got;
        got = 8'hxx;
        for (int n = 0; n < 16; n++)
        begin
            if (u_panel.digits[6] == panel_order(hex_abcdefgh(4'(n))))
                got[3:0] = 4'(n);
            if (u_panel.digits[7] == panel_order(hex_abcdefgh(4'(n))))
                got[7:4] = 4'(n);
        end
        if (got !== expected)
            report_failure($sformatf("keys read back as %h, expected %h", got, expected));
    endtask

    task automatic check_display(input logic [7:0] k);
        expect_t e;
        e = ref_display(hist, hist_n, k);
        for (int i = 0; i < 8; i++)
            check_segments(i, e.segs[i * 8 +: 8]);
        check_leds(e.leds);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    // Mirrors the I2S bit count, one delay bit then 24 bits MSB first
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            fall_cnt = 0;
            sck_prev <= 1'b0;
            mic_sd   <= 1'b0;
        end
        else
        begin
            sck_prev <= mic_sck;
            if (sck_prev && !mic_sck)
            begin
                fall_cnt = (fall_cnt + 1) % 64;
                if (mic_ws !== (fall_cnt >= 32))
                    report_failure($sformatf("mic_ws is %b at bit clock %0d of the frame",
                                             mic_ws, fall_cnt));
                if (fall_cnt == 1)
                begin
                    cur_word = next_word;
                    cur_tag  = next_tag;
                end
                if (fall_cnt >= 1 && fall_cnt <= 24)
                    mic_sd <= cur_word[24 - fall_cnt];
                else
                    mic_sd <= 1'b0;
                if (fall_cnt == 25)
                    done_tag <= cur_tag;
            end
        end
    end

    task automatic play_sample(input logic [23:0] w);
        @(posedge clk);
        issue_cnt = issue_cnt + 1;
        next_word <= w;
        next_tag  <= issue_cnt;
        while (done_tag != issue_cnt)
            @(posedge clk);
        next_word <= '0;                // Silence between samples
        hist[hist_n] = w;
        hist_n = hist_n + 1;
    endtask

    task automatic set_keys(input logic [7:0] k);
        @(posedge clk);
        key_byte <= k;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = u_panel.frame_count + n;
        while (u_panel.frame_count < target)
            @(u_panel.frame_seen);
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles == max_cycles)
        begin
            $display("timeout: panel frames stopped arriving");
            $display("*** TEST FAILED ***");
            $fatal(1, "run limit reached");
        end
    end

    initial
    begin
        logic [31:0] r;
        expect_t     e;
        void'($urandom(79092));
        clk       = 1'b0;
        rst_n     = 1'b0;
        mic_sd    = 1'b0;
        key_byte  = '0;
        next_word = '0;
        next_tag  = 0;
        done_tag  = 0;
        issue_cnt = 0;
        hist_n    = 0;
        cycles    = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (sio_stb !== 1'b1)
            report_failure("panel strobe is not idle high after reset");
        if (mic_lr !== 1'b0)
            report_failure("microphone channel select is not low for the left channel");
        wait_frames(2);
        check_display(8'h00);

        for (int i = 0; i < 20; i++)
        begin
            r = $urandom();
            play_sample(r[23:0]);
        end
        wait_frames(2);
        check_display(8'h00);

        play_sample(24'h800000);
        wait_frames(2);
        check_display(8'h00);
        check_leds(8'hff);

        set_keys(8'h5a);
        wait_frames(2);
        check_display(8'h5a);
        check_keys(8'h5a);
        set_keys(8'h26);
        wait_frames(2);
        check_keys(8'h26);

        set_keys(8'h01);                // Key 0 clears the peak
        wait_frames(2);
        hist_n = 0;
        check_display(8'h01);
        set_keys(8'h00);
        wait_frames(2);
        play_sample(24'h001234);
        wait_frames(2);
        check_display(8'h00);

        set_keys(8'h80);                // Key 7 resets the meter only
        wait_frames(2);
        hist_n = 0;
        e = ref_display(hist, hist_n, 8'h80);
        check_segments(0, e.segs[7:0]); // Scan stays on digit 0 while held
        set_keys(8'h00);
        wait_frames(2);
        check_display(8'h00);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_tm1638_model.sv ====
`default_nettype none

module tb_tm1638_model
(
    input  logic       clk,
    input  logic       sio_clk,
    input  logic       sio_stb,
    input  logic       sio_data_out,
    input  logic       sio_data_oe,
    input  logic [7:0] key_byte,
    output logic       sio_data_in
);

    logic [7:0] digits [8];             // Panel order, segment a in bit 0
    logic [7:0] leds;
    int         frame_count;
    event       frame_seen;

    logic [7:0] win_bytes [17];
    logic       clk_prev;
    logic       stb_prev;
    int         bit_cnt;
    int         read_bit;

    initial
    begin
        sio_data_in = 1'b0;
        frame_count = 0;
        bit_cnt     = 0;
        clk_prev    = 1'b1;
        stb_prev    = 1'b1;
        leds        = '0;
    end

    // ------------------------------
    // Frame decoder
    // ------------------------------

    always @(posedge clk)
    begin
        clk_prev <= sio_clk;
        stb_prev <= sio_stb;
        if (!stb_prev && sio_stb)
        begin
            if (bit_cnt == 17 * 8 && win_bytes[0] == 8'hc0)
            begin
                for (int i = 0; i < 8; i++)
                begin
                    digits[i] = win_bytes[2 * i + 1];
                    leds[i]   = win_bytes[2 * i + 2][0];
                end
                frame_count = frame_count + 1;
                -> frame_seen;
            end
            bit_cnt = 0;
        end
        else if (!sio_stb && sio_clk && !clk_prev)
        begin
            if (!(bit_cnt >= 8 && win_bytes[0] == 8'h42) && bit_cnt < 17 * 8)
                win_bytes[bit_cnt / 8][bit_cnt % 8] = sio_data_out;   // LSB first
            bit_cnt = bit_cnt + 1;
        end

        // Key i sits in bit 0 (keys 0 to 3) or bit 4 (keys 4 to 7) of byte i mod 4
        read_bit = bit_cnt - 8;
        if (!sio_data_oe && bit_cnt >= 8 && win_bytes[0] == 8'h42 && read_bit < 32)
        begin
            if (read_bit % 8 == 0)
                sio_data_in <= key_byte[read_bit / 8];
            else if (read_bit % 8 == 4)
                sio_data_in <= key_byte[read_bit / 8 + 4];
            else
                sio_data_in <= 1'b0;
        end
        else
            sio_data_in <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tm1638_board_controller.sv ====
`default_nettype none

module tm1638_board_controller
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [7:0]                         hgfedcba,
    input  logic [board_pkg::w_tm_digit - 1:0] digit,
    input  logic [board_pkg::w_tm_led - 1:0]   ledr,
    output logic [board_pkg::w_tm_key - 1:0]   keys,
    output logic                               sio_clk,
    output logic                               sio_stb,
    output logic                               sio_data_out,
    output logic                               sio_data_oe,
    input  logic                               sio_data_in
);

    logic [7:0]                                  seg_slot  [board_pkg::w_tm_digit];
    logic [7:0]                                  frame_seg [board_pkg::w_tm_digit];
    logic [board_pkg::w_tm_led - 1:0]            led_slot;
    logic [board_pkg::w_tm_led - 1:0]            frame_led;

    board_pkg::tm_state_t                        state;
    board_pkg::tm_state_t                        next_state;  // Window after the stb pulse
    board_pkg::tm_cmd_t                          opcode;
    logic [$clog2(board_pkg::tm_clk_half) - 1:0] div_cnt;
    logic                                        half_tick;
    logic                                        phase;       // Low half, then high half
    logic [2:0]                                  bit_cnt;
    logic [4:0]                                  byte_cnt;
    logic [7:0]                                  shift_reg;
    logic [7:0]                                  rx_byte;
    logic [7:0]                                  data_byte;
    logic [board_pkg::w_tm_key - 1:0]            key_acc;
    logic [board_pkg::w_tm_key - 1:0]            key_next;
    logic                                        active;
    logic                                        win_start;
    logic                                        bit_rise;
    logic                                        bit_end;
    logic                                        byte_end;

    // ------------------------------
    // Strobes and pin levels
    // ------------------------------

    assign half_tick = int'(div_cnt) == board_pkg::tm_clk_half - 1;
    assign active    = !(state inside {board_pkg::st_idle, board_pkg::st_gap});
    assign win_start = half_tick && state == board_pkg::st_idle && phase;
    assign bit_rise  = half_tick && active && !phase;
    assign bit_end   = half_tick && active && phase;
    assign byte_end  = bit_end && &bit_cnt;

    assign sio_clk      = active ? phase : 1'b1;
    assign sio_stb      = !active;
    assign sio_data_oe  = active && state != board_pkg::st_read_keys;
    assign sio_data_out = shift_reg[0];                   // LSB first

    always_comb
    begin
        case (next_state)
            board_pkg::st_cmd_write:   opcode = board_pkg::cmd_write_auto;
            board_pkg::st_addr_data:   opcode = board_pkg::cmd_addr0;
            board_pkg::st_cmd_display: opcode = board_pkg::cmd_display_on;
            default:                   opcode = board_pkg::cmd_read_keys;
        endcase
    end

    // Even bytes carry segments, odd bytes an LED in bit 0
    assign data_byte = byte_cnt[0] ? {7'b0, frame_led[byte_cnt[3:1]]}
                                   : frame_seg[byte_cnt[3:1]];

    always_comb
    begin
        key_next                        = key_acc;
        key_next[byte_cnt[1:0]]         = rx_byte[0];
        key_next[{1'b1, byte_cnt[1:0]}] = rx_byte[4];     // Keys 4 to 7 in bit 4
    end

    // ------------------------------
    // Frame sequencer
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt    <= '0;
            state      <= board_pkg::st_gap;              // Let the slots fill first
            next_state <= board_pkg::st_cmd_write;
            phase      <= 1'b0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            keys       <= '0;
        end
        else
        begin
            div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
            if (half_tick)
            begin
                case (state)
                    board_pkg::st_idle:
                    begin
                        phase <= !phase;                  // One serial period, stb high
                        if (phase)
                        begin
                            state    <= next_state;
                            byte_cnt <= '0;
                        end
                    end
                    board_pkg::st_gap:
                    begin
                        byte_cnt <= byte_cnt + 1'b1;      // 32 halves between frames
                        if (&byte_cnt)
                        begin
                            state      <= board_pkg::st_idle;
                            next_state <= board_pkg::st_cmd_write;
                        end
                    end
                    default:
                    begin
                        phase <= !phase;
                        if (phase)
                            bit_cnt <= bit_cnt + 1'b1;
                        if (byte_end)
                        begin
                            case (state)
                                board_pkg::st_cmd_write:
                                begin
                                    state      <= board_pkg::st_idle;
                                    next_state <= board_pkg::st_addr_data;
                                end
                                board_pkg::st_addr_data:
                                    if (byte_cnt == 5'd16)
                                    begin
                                        state      <= board_pkg::st_idle;
                                        next_state <= board_pkg::st_cmd_display;
                                    end
                                    else
                                        byte_cnt <= byte_cnt + 1'b1;
                                board_pkg::st_cmd_display:
                                begin
                                    state      <= board_pkg::st_idle;
                                    next_state <= board_pkg::st_cmd_read;
                                end
                                board_pkg::st_cmd_read:
                                    state <= board_pkg::st_read_keys;   // Same window
                                default:
                                    if (byte_cnt == 5'd3)
                                    begin
                                        keys     <= key_next;
                                        state    <= board_pkg::st_gap;
                                        byte_cnt <= '0;
                                    end
                                    else
                                        byte_cnt <= byte_cnt + 1'b1;
                            endcase
                        end
                    end
                endcase
            end
        end
    end

    // ------------------------------
    // Slots and shifters
    // ------------------------------

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < board_pkg::w_tm_digit; i++)
        begin
            if (digit[i])
                seg_slot[i] <= hgfedcba;
        end
        led_slot <= ledr;

        if (win_start && next_state == board_pkg::st_cmd_write)
        begin
            frame_seg <= seg_slot;                        // Snapshot for the whole frame
            frame_led <= led_slot;
        end

        if (win_start)
            shift_reg <= opcode;
        else if (byte_end && state == board_pkg::st_addr_data)
            shift_reg <= data_byte;
        else if (bit_end)
            shift_reg <= shift_reg >> 1;

        if (bit_rise)
            rx_byte <= {sio_data_in, rx_byte[7:1]};
        if (byte_end && state == board_pkg::st_read_keys)
            key_acc <= key_next;
    end

endmodule

`default_nettype wire
